/* vlog.f */
+incdir+.
mem_pkg.sv
rst_sync.sv
mem_ctrl.sv
mem_tester.sv
board_wrapper.sv
tb_board_wrapper.sv

/* Bender.yml */
package:
  name: board_wrapper

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - mem_pkg.sv
      - rst_sync.sv
      - mem_ctrl.sv
      - mem_tester.sv
      - board_wrapper.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_board_wrapper.sv

/* tb_board_wrapper.sv */
/*
 * Testbench for the board wrapper with the memory tester and controller.
 * Seeds come from a Galois LFSR, inputs change on the falling edge.
 * Expected error counts follow the pattern rule {s, s ^ a} per word.
 */
`timescale 1ns/1ps
`include "wrapper_defines.svh"

module tb_board_wrapper;

    localparam int WaitLimit = 200;

    logic              clk_i = 1'b0;
    logic              rst_n_i, pll_locked_i, start_i, verify_only_i;
    logic [31:0]       seed_i;
    logic              done_o, status_running_no, status_init_done_no, status_pass_no;
    logic [`ERR_W-1:0] err_cnt_o;

    int          cyc = 0;
    int          done_cnt = 0;
    int          runs = 0;
    int          checks = 0;
    int          errors = 0;
    int          timeouts = 0;
    int          t0;
    logic [31:0] lfsr, seed_a, seed_b, mem_seed;

    board_wrapper DUT (.*);

    always #2 clk_i = ~clk_i;
    always @(posedge clk_i) cyc <= cyc + 1;
    // Outputs are stable mid-cycle
    always @(negedge clk_i) if (done_o) done_cnt <= done_cnt + 1;

    // ##################################################
    // Concurrent checks
    // ##################################################

    assert property (@(posedge clk_i) done_o |=> !done_o)
        else begin
            errors++;
            $display("[ERROR] %0t done_o exp 0 got 1 (strobe longer than one cycle)", $time);
        end

    assert property (@(posedge clk_i) !(rst_n_i && pll_locked_i) |-> status_running_no)
        else begin
            errors++;
            $display("[ERROR] %0t status_running_no exp 1 got %b", $time, status_running_no);
        end

    // ##################################################
    // Helpers
    // ##################################################

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic next_seed(output logic [31:0] seed);
        for (int i = 0; i < 32; i++) begin
            lfsr = lfsr_step(lfsr);
            seed = {seed[30:0], lfsr[0]};
        end
    endtask

    // Words written with one seed that fail a check with another
    function automatic int count_mismatch(input logic [31:0] ws, input logic [31:0] rs);
        int n;
        n = 0;
        for (int a = 0; a < `TEST_WORDS; a++) begin
            if ({ws, ws ^ 32'(a)} != {rs, rs ^ 32'(a)}) n++;
        end
        return n;
    endfunction

    function automatic logic watched(input int sel);
        case (sel)
            0: return !status_running_no;
            1: return !status_init_done_no;
            default: return done_o;
        endcase
    endfunction

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[ERROR] %0t %s exp %0h got %0h", $time, name, exp, got);
        end
    endtask

    // Sample at falling edges until the event, bounded
    task automatic wait_for(input int sel, input string what);
        int n;
        n = 0;
        while (!watched(sel) && n < WaitLimit) begin
            @(negedge clk_i);
            n++;
        end
        if (!watched(sel)) begin
            timeouts++;
            $display("Timeout at %0t while waiting for %s", $time, what);
        end
    endtask

    task automatic pulse_start(input logic [31:0] seed, input logic vo);
        start_i       = 1'b1;
        seed_i        = seed;
        verify_only_i = vo;
        runs++;
        if (!vo) mem_seed = seed;
        @(negedge clk_i);
        start_i = 1'b0;
    endtask

    // Done, error count, then the pass LED one cycle later
    task automatic finish_run(input logic [31:0] seed);
        int exp_err;
        exp_err = count_mismatch(mem_seed, seed);
        wait_for(2, "done_o");
        check_val("err_cnt_o", err_cnt_o, exp_err);
        @(negedge clk_i);
        check_val("status_pass_no", status_pass_no, exp_err != 0);
        check_val("done count", done_cnt, runs);
        @(negedge clk_i);
    endtask

    task automatic do_run(input logic [31:0] seed, input logic vo);
        pulse_start(seed, vo);
        finish_run(seed);
    endtask

    // ##################################################
    // Stimulus
    // ##################################################

    initial begin
        rst_n_i       = 1'b0;
        pll_locked_i  = 1'b0;
        start_i       = 1'b0;
        verify_only_i = 1'b0;
        seed_i        = '0;
        lfsr          = 32'h9398d960;
        repeat (10) @(negedge clk_i);
        check_val("status_running_no", status_running_no, 1);
        check_val("status_pass_no", status_pass_no, 1);

        // Reset released, lock still missing
        rst_n_i = 1'b1;
        repeat (6) @(negedge clk_i);
        check_val("status_running_no", status_running_no, 1);
        pll_locked_i = 1'b1;
        t0 = cyc;
        wait_for(0, "status_running_no low");
        check_val("reset release cycles", cyc - t0, `RST_STAGES);

        // Calibration done first, so lock loss must clear it
        wait_for(1, "status_init_done_no low");

        // Lock loss resets at once
        @(negedge clk_i);
        pll_locked_i = 1'b0;
        #1;
        check_val("status_running_no", status_running_no, 1);
        check_val("status_init_done_no", status_init_done_no, 1);
        @(negedge clk_i);
        pll_locked_i = 1'b1;
        t0 = cyc;
        wait_for(0, "status_running_no low");
        check_val("reset release cycles", cyc - t0, `RST_STAGES);

        // Start during calibration
        t0 = cyc;
        next_seed(seed_a);
        pulse_start(seed_a, 1'b0);
        wait_for(1, "status_init_done_no low");
        check_val("calibration cycles", cyc - t0, `CALIB_CYCLES);
        finish_run(seed_a);

        // Same seed, then a different one
        do_run(seed_a, 1'b1);
        do begin
            next_seed(seed_b);
        end while (seed_b == seed_a);
        do_run(seed_b, 1'b1);

        // Back to back runs across refresh stalls
        for (int i = 0; i < 3; i++) begin
            next_seed(seed_a);
            do_run(seed_a, 1'b0);
            do_run(seed_a, 1'b1);
            do_run(seed_b, 1'b1);
        end
        check_val("done count", done_cnt, runs);

        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule : tb_board_wrapper

/* board_wrapper.sv */
/*
 * Board wrapper around the memory tester and the on-chip controller.
 * The PLL lock is an input, clk_i is taken as the system clock.
 * Status LEDs are active low and read "not ready" from reset.
 */
`timescale 1ns/1ps
`include "wrapper_defines.svh"

module board_wrapper (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              pll_locked_i,

    // Test control
    input  logic              start_i,
    input  logic              verify_only_i,
    input  logic [31:0]       seed_i,
    output logic              done_o,
    output logic [`ERR_W-1:0] err_cnt_o,

    // Status LEDs
    output logic              status_running_no,   // Out of reset
    output logic              status_init_done_no, // Calibration finished
    output logic              status_pass_no       // Last run had no errors
);

    // ##################################################
    // Signals
    // ##################################################

    logic rst_sys_req_n;
    logic rst_sys_n;
    logic init_done;
    logic pass_q;

    // Command
    logic                 mctrl_cmd_ready, mctrl_cmd_valid, mctrl_cmd_read;
    mem_pkg::mctrl_addr_t mctrl_cmd_addr;

    // Write data
    logic                 mctrl_wdata_ready, mctrl_wdata_valid;
    mem_pkg::mctrl_data_t mctrl_wdata;
    mem_pkg::mctrl_mask_t mctrl_wmask;

    // Read data
    logic                 mctrl_rdata_valid;
    mem_pkg::mctrl_data_t mctrl_rdata;

    // ##################################################
    // Reset
    // ##################################################

    // Held in reset while the clock is not locked
    assign rst_sys_req_n = rst_n_i && pll_locked_i;

    rst_sync #(
        .NumRegs( `RST_STAGES )
    ) i_rst_sync (
        .clk_i  ( clk_i         ),
        .rst_n_i( rst_sys_req_n ),
        .rst_n_o( rst_sys_n     )
    );

    assign status_running_no = !rst_sys_n;

    // ##################################################
    // Tester and controller
    // ##################################################

    mem_tester i_tester (
        .clk_i              ( clk_i             ),
        .rst_n_i            ( rst_sys_n         ),
        .start_i            ( start_i           ),
        .verify_only_i      ( verify_only_i     ),
        .seed_i             ( seed_i            ),
        .mctrl_cmd_valid_o  ( mctrl_cmd_valid   ),
        .mctrl_cmd_read_o   ( mctrl_cmd_read    ),
        .mctrl_cmd_addr_o   ( mctrl_cmd_addr    ),
        .mctrl_cmd_ready_i  ( mctrl_cmd_ready   ),
        .mctrl_wdata_valid_o( mctrl_wdata_valid ),
        .mctrl_wdata_o      ( mctrl_wdata       ),
        .mctrl_wmask_o      ( mctrl_wmask       ),
        .mctrl_wdata_ready_i( mctrl_wdata_ready ),
        .mctrl_rdata_valid_i( mctrl_rdata_valid ),
        .mctrl_rdata_i      ( mctrl_rdata       ),
        .done_o             ( done_o            ),
        .err_cnt_o          ( err_cnt_o         )
    );

    mem_ctrl i_mem_ctrl (
        .clk_i        ( clk_i             ),
        .rst_n_i      ( rst_sys_n         ),
        .init_done_o  ( init_done         ),
        .cmd_valid_i  ( mctrl_cmd_valid   ),
        .cmd_read_i   ( mctrl_cmd_read    ),
        .cmd_addr_i   ( mctrl_cmd_addr    ),
        .cmd_ready_o  ( mctrl_cmd_ready   ),
        .wdata_valid_i( mctrl_wdata_valid ),
        .wdata_i      ( mctrl_wdata       ),
        .wmask_i      ( mctrl_wmask       ),
        .wdata_ready_o( mctrl_wdata_ready ),
        .rdata_valid_o( mctrl_rdata_valid ),
        .rdata_o      ( mctrl_rdata       )
    );

    assign status_init_done_no = !init_done;

    // ##################################################
    // Pass flag
    // ##################################################

    // Updated on every done, cleared by reset
    always_ff @(posedge clk_i or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            pass_q <= 1'b0;
        end else if (done_o) begin
            pass_q <= (err_cnt_o == '0);
        end
    end

    assign status_pass_no = !pass_q;

endmodule : board_wrapper

/* mem_tester.sv */
/*
 * Memory pattern tester for the mctrl handshake.
 * Word a for seed s is {s, s ^ a}, with a zero-extended to 32 bits.
 * start_i is honoured only while idle. err_cnt_o saturates and holds
 * from done_o until the next start. Read data must come back in order.
 */
`timescale 1ns/1ps
`include "wrapper_defines.svh"

module mem_tester (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    // Control
    input  logic                  start_i,
    input  logic                  verify_only_i,
    input  logic [31:0]           seed_i,

    // Command
    output logic                  mctrl_cmd_valid_o,
    output logic                  mctrl_cmd_read_o,
    output mem_pkg::mctrl_addr_t  mctrl_cmd_addr_o,
    input  logic                  mctrl_cmd_ready_i,

    // Write data
    output logic                  mctrl_wdata_valid_o,
    output mem_pkg::mctrl_data_t  mctrl_wdata_o,
    output mem_pkg::mctrl_mask_t  mctrl_wmask_o,
    input  logic                  mctrl_wdata_ready_i,

    // Read data
    input  logic                  mctrl_rdata_valid_i,
    input  mem_pkg::mctrl_data_t  mctrl_rdata_i,

    // Result
    output logic                  done_o,
    output logic [`ERR_W-1:0]     err_cnt_o
);

    // Counter wide enough to hold TEST_WORDS itself
    localparam int unsigned CntW = $clog2(`TEST_WORDS) + 1;

    // Expected word for a seed and address
    function automatic mem_pkg::mctrl_data_t pattern(
        input logic [31:0]          seed,
        input mem_pkg::mctrl_addr_t addr
    );
        return {seed, seed ^ 32'(addr)};
    endfunction

    // ##################################################
    // State
    // ##################################################

    mem_pkg::tester_state_e state_q;
    logic [31:0]            seed_q;
    logic [CntW-1:0]        issue_cnt_q;
    logic [CntW-1:0]        exp_cnt_q;
    logic [`ERR_W-1:0]      err_cnt_q;
    logic                   done_q;

    mem_pkg::mctrl_addr_t   issue_addr;
    mem_pkg::mctrl_addr_t   exp_addr;
    logic                   cmd_fire;
    logic                   last_issue;
    logic                   mismatch;

    assign issue_addr = mem_pkg::mctrl_addr_t'(issue_cnt_q);
    assign exp_addr   = mem_pkg::mctrl_addr_t'(exp_cnt_q);
    assign last_issue = (issue_cnt_q == CntW'(`TEST_WORDS - 1));

    // ##################################################
    // Bus outputs
    // ##################################################

    // Valids come straight from the phase, so they hold until accepted
    assign mctrl_cmd_valid_o   = (state_q == mem_pkg::WRITE) || (state_q == mem_pkg::READ);
    assign mctrl_cmd_read_o    = (state_q == mem_pkg::READ);
    assign mctrl_cmd_addr_o    = issue_addr;
    assign mctrl_wdata_valid_o = (state_q == mem_pkg::WRITE);
    assign mctrl_wdata_o       = pattern(seed_q, issue_addr);
    assign mctrl_wmask_o       = '1;

    // Writes also need the data channel
    assign cmd_fire = mctrl_cmd_valid_o && mctrl_cmd_ready_i
                   && (mctrl_cmd_read_o || mctrl_wdata_ready_i);

    // Check in arrival order
    assign mismatch = (mctrl_rdata_i != pattern(seed_q, exp_addr));

    // ##################################################
    // Phase machine
    // ##################################################

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= mem_pkg::IDLE;
            issue_cnt_q <= '0;
            exp_cnt_q   <= '0;
            err_cnt_q   <= '0;
            done_q      <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                mem_pkg::IDLE: begin
                    if (start_i) begin
                        issue_cnt_q <= '0;
                        exp_cnt_q   <= '0;
                        err_cnt_q   <= '0;
                        // Verify-only skips the write pass
                        state_q     <= verify_only_i ? mem_pkg::READ : mem_pkg::WRITE;
                    end
                end
                mem_pkg::WRITE: begin
                    if (cmd_fire) begin
                        issue_cnt_q <= last_issue ? '0 : issue_cnt_q + 1'b1;
                        if (last_issue) state_q <= mem_pkg::READ;
                    end
                end
                mem_pkg::READ: begin
                    if (cmd_fire) begin
                        issue_cnt_q <= issue_cnt_q + 1'b1;
                        if (last_issue) state_q <= mem_pkg::DRAIN;
                    end
                end
                mem_pkg::DRAIN: begin
                    // All words back, report once
                    if (exp_cnt_q == CntW'(`TEST_WORDS)) begin
                        done_q  <= 1'b1;
                        state_q <= mem_pkg::IDLE;
                    end
                end
                default: state_q <= mem_pkg::IDLE;
            endcase

            // Read data tracking, runs beside the phase logic
            if (mctrl_rdata_valid_i && state_q != mem_pkg::IDLE) begin
                exp_cnt_q <= exp_cnt_q + 1'b1;
                if (mismatch && err_cnt_q != '1) begin
                    err_cnt_q <= err_cnt_q + 1'b1;
                end
            end
        end
    end

    // Seed is payload, latched on start only
    always_ff @(posedge clk_i) begin
        if (state_q == mem_pkg::IDLE && start_i) begin
            seed_q <= seed_i;
        end
    end

    assign done_o    = done_q;
    assign err_cnt_o = err_cnt_q;

endmodule : mem_tester

/* mem_ctrl.sv */
/*
 * On-chip memory controller with a DDR3-style command handshake.
 * Readies stay low for CALIB_CYCLES after reset, then drop for one
 * cycle every REFRESH_PERIOD cycles. Reads return after READ_LAT cycles
 * in command order, without back-pressure. A write needs cmd and wdata
 * valid in the same cycle. Storage contents are undefined after power-up.
 */
`timescale 1ns/1ps
`include "wrapper_defines.svh"

module mem_ctrl (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    output logic                  init_done_o,

    // Command
    input  logic                  cmd_valid_i,
    input  logic                  cmd_read_i,
    input  mem_pkg::mctrl_addr_t  cmd_addr_i,
    output logic                  cmd_ready_o,

    // Write data
    input  logic                  wdata_valid_i,
    input  mem_pkg::mctrl_data_t  wdata_i,
    input  mem_pkg::mctrl_mask_t  wmask_i,
    output logic                  wdata_ready_o,

    // Read data
    output logic                  rdata_valid_o,
    output mem_pkg::mctrl_data_t  rdata_o
);

    // ##################################################
    // Local parameters
    // ##################################################

    localparam int unsigned CalibW = $clog2(`CALIB_CYCLES + 1);
    localparam int unsigned RefW   = $clog2(`REFRESH_PERIOD);
    localparam int unsigned Depth  = 2 ** `MCTRL_ADDR_W;
    localparam int unsigned Bytes  = `MCTRL_DATA_W / 8;

    // ##################################################
    // Calibration and refresh
    // ##################################################

    logic [CalibW-1:0] calib_cnt_q;
    logic              init_done_q;
    logic [RefW-1:0]   refresh_cnt_q;
    logic              refresh_stall;
    logic              ready;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            calib_cnt_q   <= '0;
            init_done_q   <= 1'b0;
            refresh_cnt_q <= '0;
        end else if (!init_done_q) begin
            // Calibration wait
            calib_cnt_q <= calib_cnt_q + 1'b1;
            if (calib_cnt_q == CalibW'(`CALIB_CYCLES - 1)) begin
                init_done_q <= 1'b1;
            end
        end else if (refresh_cnt_q == RefW'(`REFRESH_PERIOD - 1)) begin
            refresh_cnt_q <= '0;
        end else begin
            refresh_cnt_q <= refresh_cnt_q + 1'b1;
        end
    end

    // Last slot of each refresh period blocks all traffic
    assign refresh_stall = (refresh_cnt_q == RefW'(`REFRESH_PERIOD - 1));
    assign ready         = init_done_q && !refresh_stall;

    assign init_done_o   = init_done_q;
    assign cmd_ready_o   = ready;
    assign wdata_ready_o = ready;

    // ##################################################
    // Storage
    // ##################################################

    mem_pkg::mctrl_data_t mem_q [Depth];
    logic                 wr_fire;
    logic                 rd_fire;

    // Write needs both channels at once
    assign wr_fire = ready && cmd_valid_i && !cmd_read_i && wdata_valid_i;
    assign rd_fire = ready && cmd_valid_i && cmd_read_i;

    always_ff @(posedge clk_i) begin
        if (wr_fire) begin
            for (int unsigned b = 0; b < Bytes; b++) begin
                if (wmask_i[b]) begin
                    mem_q[cmd_addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    // ##################################################
    // Read pipeline
    // ##################################################

    logic [`READ_LAT-1:0] rd_valid_q;
    mem_pkg::mctrl_data_t rd_data_q [`READ_LAT];

    // Valid bits carry control, reset them
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_valid_q <= '0;
        end else begin
            rd_valid_q <= {rd_valid_q[`READ_LAT-2:0], rd_fire};
        end
    end

    // Data stages follow the valid bits
    always_ff @(posedge clk_i) begin
        rd_data_q[0] <= mem_q[cmd_addr_i];
        for (int unsigned i = 1; i < `READ_LAT; i++) begin
            rd_data_q[i] <= rd_data_q[i-1];
        end
    end

    assign rdata_valid_o = rd_valid_q[`READ_LAT-1];
    assign rdata_o       = rd_data_q[`READ_LAT-1];

endmodule : mem_ctrl

/* rst_sync.sv */
/*
 * Reset synchroniser for an active-low reset request.
 * Assertion is asynchronous, release takes NumRegs rising edges.
 * NumRegs must be at least 2 for metastability protection.
 */
`timescale 1ns/1ps

module rst_sync #(
    parameter int unsigned NumRegs = 4
) (
    input  logic clk_i,
    input  logic rst_n_i, // Reset request, may be asynchronous
    output logic rst_n_o  // Synchronised reset
);

    // Shift chain, all zero while the request is low
    logic [NumRegs-1:0] sync_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync_q <= '0;
        end else begin
            // Ones walk in from the bottom
            sync_q <= {sync_q[NumRegs-2:0], 1'b1};
        end
    end

    // Last stage drives the system reset
    assign rst_n_o = sync_q[NumRegs-1];

endmodule : rst_sync

/* mem_pkg.sv */
/*
 * Memory bus payload types and the tester phase encoding.
 * Widths follow the macros of the wrapper defines header.
 * One mask bit covers one data byte.
 */
`include "wrapper_defines.svh"

package mem_pkg;

    // ##################################################
    // Memory controller bus
    // ##################################################

    // Word address, not byte address
    typedef logic [`MCTRL_ADDR_W-1:0] mctrl_addr_t;

    // One full data beat
    typedef logic [`MCTRL_DATA_W-1:0] mctrl_data_t;

    // Byte enables, bit b covers data[8*b +: 8]
    typedef logic [`MCTRL_DATA_W/8-1:0] mctrl_mask_t;

    // ##################################################
    // Pattern tester
    // ##################################################

    // Phases of one test run
    typedef enum logic [1:0] {
        IDLE,  // Waiting for start
        WRITE, // Issuing pattern writes
        READ,  // Issuing read commands
        DRAIN  // Waiting for the last read data
    } tester_state_e;

endpackage : mem_pkg

/* wrapper_defines.svh */
/*
 * Shared constants for the board wrapper and its memory blocks.
 * MCTRL_DATA_W must be a multiple of 8 and equal to 64, since a pattern
 * word is two 32-bit halves. TEST_WORDS must not exceed 2**MCTRL_ADDR_W.
 */
`ifndef WRAPPER_DEFINES_SVH
`define WRAPPER_DEFINES_SVH

// Memory bus widths
`define MCTRL_DATA_W 64
`define MCTRL_ADDR_W 8

// Reset synchroniser depth
`define RST_STAGES 4

// Controller timing, counted in system clock cycles
`define CALIB_CYCLES 20
`define REFRESH_PERIOD 32
`define READ_LAT 3

// Tester sizing
`define TEST_WORDS 16
`define ERR_W 16

`endif
